/* Bender.yml */
package:
  name: cdc_bridge

sources:
  - verilog/cdc_bridge_pkg.sv
  - verilog/toggle_sync.sv
  - verilog/slave_port.sv
  - verilog/master_port.sv
  - verilog/cdc_bridge.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/cdc_bridge_assert.sv
      - tb/tb_cdc_bridge.sv

/* cdc_bridge.f */
verilog/cdc_bridge_pkg.sv
verilog/toggle_sync.sv
verilog/slave_port.sv
verilog/master_port.sv
verilog/cdc_bridge.sv
tb/tb_clock_gen.sv
tb/cdc_bridge_assert.sv
tb/tb_cdc_bridge.sv

/* tb/cdc_bridge_assert.sv */
// port checks on the cdc bridge for idle levels, strobe rules and back-pressure
`timescale 1ns/1ns

module cdc_bridge_assert (
  input logic                              slave_clk,
  input logic                              slave_reset_n,
  input logic                              slave_read,
  input logic                              slave_write,
  input logic                              slave_waitrequest,
  input logic                              master_clk,
  input logic                              master_reset_n,
  input logic                              master_waitrequest,
  input logic                              master_read,
  input logic                              master_write,
  input logic [cdc_bridge_pkg::ADDR_W-1:0] master_address,
  input logic [cdc_bridge_pkg::DATA_W-1:0] master_writedata
);

  // slave command seen but not yet accepted
  logic outstanding;
  int   err_count = 0;

  always_ff @(posedge slave_clk or negedge slave_reset_n)
  begin
    if (!slave_reset_n)
    begin
      outstanding <= 1'b0;
    end
    else if ((slave_read || slave_write) && !slave_waitrequest)
    begin
      outstanding <= 1'b0;
    end
    else if (slave_read || slave_write)
    begin
      outstanding <= 1'b1;
    end
  end

  a_idle_no_wait: assert property (@(posedge slave_clk) disable iff (!slave_reset_n)
    (!slave_read && !slave_write && !outstanding) |-> !slave_waitrequest)
  else
  begin
    err_count++;
    $error("waitrequest high with no slave command present");
  end

  // strobes only while a slave command is pending
  a_strobe_needs_cmd: assert property (@(posedge master_clk) disable iff (!master_reset_n)
    !outstanding |-> (!master_read && !master_write))
  else
  begin
    err_count++;
    $error("master strobe high with no slave command outstanding");
  end

  a_hold_on_wait: assert property (@(posedge master_clk) disable iff (!master_reset_n)
    ((master_read || master_write) && master_waitrequest) |=>
      ($stable(master_read) && $stable(master_write) &&
       $stable(master_address) && $stable(master_writedata)))
  else
  begin
    err_count++;
    $error("master port changed while waitrequest was high");
  end

  a_strobe_exclusive: assert property (@(posedge master_clk) disable iff (!master_reset_n)
    !(master_read && master_write))
  else
  begin
    err_count++;
    $error("master read and write strobes high together");
  end

endmodule

/* tb/tb_cdc_bridge.sv */
// cdc bridge testbench driving random reads and writes against a master-side responder
`timescale 1ns/1ns

module tb_cdc_bridge;

  localparam int                              SEED     = 32'h73f65181;
  localparam int                              N_XFERS  = 200;
  localparam logic [cdc_bridge_pkg::DATA_W-1:0] READ_XOR = 8'h5A;
  // 60 master cycles per transfer plus the reset time
  localparam longint WATCHDOG_NS = (N_XFERS * 60 + 16) * 100;

  logic                              master_clk;
  logic                              slave_clk;
  logic                              master_reset_n;
  logic                              slave_reset_n;
  logic                              slave_read;
  logic                              slave_write;
  logic [cdc_bridge_pkg::ADDR_W-1:0] slave_address;
  logic [cdc_bridge_pkg::DATA_W-1:0] slave_writedata;
  logic                              slave_waitrequest;
  logic [cdc_bridge_pkg::DATA_W-1:0] slave_readdata;
  logic                              master_waitrequest;
  logic [cdc_bridge_pkg::DATA_W-1:0] master_readdata;
  logic                              master_read;
  logic                              master_write;
  logic [cdc_bridge_pkg::ADDR_W-1:0] master_address;
  logic [cdc_bridge_pkg::DATA_W-1:0] master_writedata;

  int seed          = SEED;
  int writes_issued = 0;
  int write_accepts = 0;
  // address and data of each write still expected on the master port
  logic [cdc_bridge_pkg::ADDR_W+cdc_bridge_pkg::DATA_W-1:0] write_q[$];

  tb_clock_gen u_clk_gen (.*);

  cdc_bridge u_dut (.*);

  bind cdc_bridge cdc_bridge_assert u_assert (.*);

  // address zero-extended then xor'ed with the responder pattern
  function automatic logic [cdc_bridge_pkg::DATA_W-1:0] expected_readdata(
    input logic [cdc_bridge_pkg::ADDR_W-1:0] addr
  );
    logic [cdc_bridge_pkg::DATA_W-1:0] wide;
    wide = '0;
    wide[cdc_bridge_pkg::ADDR_W-1:0] = addr;
    return wide ^ READ_XOR;
  endfunction

  task automatic fail_and_stop(input string line);
    $display("%s", line);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    fail_and_stop($sformatf("FAIL %0t: %s", $time, msg));
  endtask

  task automatic run_transfer(
    input logic                              is_read,
    input logic [cdc_bridge_pkg::ADDR_W-1:0] addr,
    input logic [cdc_bridge_pkg::DATA_W-1:0] data
  );
    slave_address   = addr;
    slave_writedata = data;
    slave_read      = is_read;
    slave_write     = !is_read;
    if (!is_read)
    begin
      write_q.push_back({addr, data});
      writes_issued++;
    end
    // waitrequest low mid-cycle means accepted on the next edge
    do
    begin
      @(negedge slave_clk);
    end
    while (slave_waitrequest);
    if (is_read)
    begin
      assert (slave_readdata == expected_readdata(addr))
      else report_mismatch($sformatf("read of %0h returned %0h, expected %0h",
        addr, slave_readdata, expected_readdata(addr)));
    end
    @(posedge slave_clk);
    #5;
  endtask

  initial
  begin
    logic [31:0] rnd;
    slave_read         = 1'b0;
    slave_write        = 1'b0;
    slave_address      = '0;
    slave_writedata    = '0;
    master_waitrequest = 1'b1;
    master_readdata    = '0;
    wait (slave_reset_n && master_reset_n);
    @(posedge slave_clk);
    #5;
    for (int i = 0; i < N_XFERS; i++)
    begin
      rnd = $random(seed);
      // occasional idle gap between commands
      if (rnd[17:16] != 2'd0)
      begin
        slave_read  = 1'b0;
        slave_write = 1'b0;
        repeat (rnd[17:16]) @(posedge slave_clk);
        #5;
      end
      run_transfer(rnd[0], rnd[7:4], rnd[15:8]);
    end
    slave_read  = 1'b0;
    slave_write = 1'b0;
    repeat (4) @(posedge master_clk);
    if (write_q.size() == 0 && write_accepts == writes_issued)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      report_mismatch($sformatf("%0d writes issued, %0d accepted on the master port",
        writes_issued, write_accepts));
    end
  end

  // responder with random back-pressure
  always
  begin
    logic [31:0] rnd;
    @(posedge master_clk);
    #5;
    rnd = $random(seed);
    if (master_reset_n)
    begin
      master_waitrequest = rnd[0];
      master_readdata    = master_read ? expected_readdata(master_address) : rnd[15:8];
    end
  end

  always @(negedge master_clk)
  begin
    if (master_reset_n && master_write && !master_waitrequest)
    begin
      assert (write_q.size() != 0)
      else fail_and_stop("master port wrote while no write was pending on the slave side");
      assert ({master_address, master_writedata} == write_q[0])
      else report_mismatch($sformatf("master write %0h/%0h, expected %0h",
        master_address, master_writedata, write_q[0]));
      void'(write_q.pop_front());
      write_accepts++;
    end
  end

  always @(u_dut.u_assert.err_count)
  begin
    if (u_dut.u_assert.err_count != 0)
    begin
      fail_and_stop("a bound assertion on the bridge ports failed");
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    fail_and_stop($sformatf("watchdog expired at %0t with transfers still running", $time));
  end

endmodule

/* tb/tb_clock_gen.sv */
// testbench clock and reset source for both bridge domains
`timescale 1ns/1ns

module tb_clock_gen (
  output logic master_clk,
  output logic slave_clk,
  output logic master_reset_n,
  output logic slave_reset_n
);

  initial
  begin
    master_clk     = 1'b0;
    slave_clk      = 1'b0;
    master_reset_n = 1'b0;
    slave_reset_n  = 1'b0;
    // both resets held for 16 master cycles, released between edges
    repeat (16) @(posedge master_clk);
    #20;
    master_reset_n = 1'b1;
    slave_reset_n  = 1'b1;
  end

  always #50 master_clk = ~master_clk;

  always #35 slave_clk = ~slave_clk;

endmodule

/* verilog/cdc_bridge.sv */
// cdc bridge top, replays single slave-domain transfers on the master-domain port
`timescale 1ns/1ns

module cdc_bridge (
  input  logic                              slave_clk,
  input  logic                              slave_reset_n,
  input  logic                              slave_read,
  input  logic                              slave_write,
  input  logic [cdc_bridge_pkg::ADDR_W-1:0] slave_address,
  input  logic [cdc_bridge_pkg::DATA_W-1:0] slave_writedata,
  output logic                              slave_waitrequest,
  output logic [cdc_bridge_pkg::DATA_W-1:0] slave_readdata,
  input  logic                              master_clk,
  input  logic                              master_reset_n,
  input  logic                              master_waitrequest,
  input  logic [cdc_bridge_pkg::DATA_W-1:0] master_readdata,
  output logic                              master_read,
  output logic                              master_write,
  output logic [cdc_bridge_pkg::ADDR_W-1:0] master_address,
  output logic [cdc_bridge_pkg::DATA_W-1:0] master_writedata
);

  // slave to master crossings
  logic                              read_req_toggle;
  logic                              write_req_toggle;
  logic [cdc_bridge_pkg::ADDR_W-1:0] slave_address_q;
  logic [cdc_bridge_pkg::DATA_W-1:0] slave_writedata_q;

  // master to slave crossings
  logic                              read_done_toggle;
  logic                              write_done_toggle;
  logic [cdc_bridge_pkg::DATA_W-1:0] read_capture;

  slave_port u_slave_port (
    .slave_clk         (slave_clk),
    .slave_reset_n     (slave_reset_n),
    .slave_read        (slave_read),
    .slave_write       (slave_write),
    .slave_address     (slave_address),
    .slave_writedata   (slave_writedata),
    .read_done_toggle  (read_done_toggle),
    .write_done_toggle (write_done_toggle),
    .read_capture      (read_capture),
    .slave_waitrequest (slave_waitrequest),
    .slave_readdata    (slave_readdata),
    .read_req_toggle   (read_req_toggle),
    .write_req_toggle  (write_req_toggle),
    .slave_address_q   (slave_address_q),
    .slave_writedata_q (slave_writedata_q)
  );

  master_port u_master_port (
    .master_clk         (master_clk),
    .master_reset_n     (master_reset_n),
    .master_waitrequest (master_waitrequest),
    .master_readdata    (master_readdata),
    .read_req_toggle    (read_req_toggle),
    .write_req_toggle   (write_req_toggle),
    .slave_address_q    (slave_address_q),
    .slave_writedata_q  (slave_writedata_q),
    .master_read        (master_read),
    .master_write       (master_write),
    .master_address     (master_address),
    .master_writedata   (master_writedata),
    .read_done_toggle   (read_done_toggle),
    .write_done_toggle  (write_done_toggle),
    .read_capture       (read_capture)
  );

endmodule

/* verilog/cdc_bridge_pkg.sv */
// cdc bridge shared widths, synchronizer depth and transfer state encoding
package cdc_bridge_pkg;

  // data bus width for both ports
  localparam int DATA_W = 8;

  // word address, wide enough to tell transfers apart
  localparam int ADDR_W = 4;

  // flops per crossing before edge detection
  localparam int SYNC_DEPTH = 2;

  // one-hot transfer state, shared by slave and master FSMs
  typedef enum logic [2:0] {
    IDLE       = 3'b001,
    READ_WAIT  = 3'b010,
    WRITE_WAIT = 3'b100
  } xfer_state_e;

endpackage

/* verilog/master_port.sv */
// master side of the cdc bridge: transfer FSM, read/write strobes, done toggles and data registers
`timescale 1ns/1ns

module master_port (
  input  logic                              master_clk,
  input  logic                              master_reset_n,
  input  logic                              master_waitrequest,
  input  logic [cdc_bridge_pkg::DATA_W-1:0] master_readdata,
  input  logic                              read_req_toggle,
  input  logic                              write_req_toggle,
  input  logic [cdc_bridge_pkg::ADDR_W-1:0] slave_address_q,
  input  logic [cdc_bridge_pkg::DATA_W-1:0] slave_writedata_q,
  output logic                              master_read,
  output logic                              master_write,
  output logic [cdc_bridge_pkg::ADDR_W-1:0] master_address,
  output logic [cdc_bridge_pkg::DATA_W-1:0] master_writedata,
  output logic                              read_done_toggle,
  output logic                              write_done_toggle,
  output logic [cdc_bridge_pkg::DATA_W-1:0] read_capture
);

  cdc_bridge_pkg::xfer_state_e state_q;
  cdc_bridge_pkg::xfer_state_e state_d;
  logic                        read_done_d;
  logic                        write_done_d;
  logic                        read_req_pulse;
  logic                        write_req_pulse;
  logic                        read_accept;

  // request tokens from the slave domain
  toggle_sync u_read_req_sync (
    .master_clk     (master_clk),
    .master_reset_n (master_reset_n),
    .toggle_in      (read_req_toggle),
    .pulse_out      (read_req_pulse)
  );

  toggle_sync u_write_req_sync (
    .master_clk     (master_clk),
    .master_reset_n (master_reset_n),
    .toggle_in      (write_req_toggle),
    .pulse_out      (write_req_pulse)
  );

  // one-hot state bits are the strobes themselves
  assign master_read  = (state_q == cdc_bridge_pkg::READ_WAIT);
  assign master_write = (state_q == cdc_bridge_pkg::WRITE_WAIT);

  assign read_accept = master_read && !master_waitrequest;

  always_comb
  begin
    state_d      = state_q;
    read_done_d  = read_done_toggle;
    write_done_d = write_done_toggle;
    case (state_q)
      cdc_bridge_pkg::IDLE:
      begin
        if (read_req_pulse)
        begin
          state_d = cdc_bridge_pkg::READ_WAIT;
        end
        else if (write_req_pulse)
        begin
          state_d = cdc_bridge_pkg::WRITE_WAIT;
        end
      end
      cdc_bridge_pkg::READ_WAIT:
      begin
        // hold the strobe until the far side stops waiting
        if (!master_waitrequest)
        begin
          state_d     = cdc_bridge_pkg::IDLE;
          read_done_d = ~read_done_toggle;
        end
      end
      cdc_bridge_pkg::WRITE_WAIT:
      begin
        if (!master_waitrequest)
        begin
          state_d      = cdc_bridge_pkg::IDLE;
          write_done_d = ~write_done_toggle;
        end
      end
      default:
      begin
        state_d = cdc_bridge_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge master_clk or negedge master_reset_n)
  begin
    if (!master_reset_n)
    begin
      state_q           <= cdc_bridge_pkg::IDLE;
      read_done_toggle  <= 1'b0;
      write_done_toggle <= 1'b0;
    end
    else
    begin
      state_q           <= state_d;
      read_done_toggle  <= read_done_d;
      write_done_toggle <= write_done_d;
    end
  end

  // slave side keeps these stable from before the request toggle flips
  always_ff @(posedge master_clk)
  begin
    master_address   <= slave_address_q;
    master_writedata <= slave_writedata_q;
  end

  // read data caught on the accepting edge, picked up by the slave domain
  always_ff @(posedge master_clk)
  begin
    if (read_accept)
    begin
      read_capture <= master_readdata;
    end
  end

endmodule

/* verilog/slave_port.sv */
// slave side of the cdc bridge: transfer FSM, waitrequest, request toggles and data registers
`timescale 1ns/1ns

module slave_port (
  input  logic                              slave_clk,
  input  logic                              slave_reset_n,
  input  logic                              slave_read,
  input  logic                              slave_write,
  input  logic [cdc_bridge_pkg::ADDR_W-1:0] slave_address,
  input  logic [cdc_bridge_pkg::DATA_W-1:0] slave_writedata,
  input  logic                              read_done_toggle,
  input  logic                              write_done_toggle,
  input  logic [cdc_bridge_pkg::DATA_W-1:0] read_capture,
  output logic                              slave_waitrequest,
  output logic [cdc_bridge_pkg::DATA_W-1:0] slave_readdata,
  output logic                              read_req_toggle,
  output logic                              write_req_toggle,
  output logic [cdc_bridge_pkg::ADDR_W-1:0] slave_address_q,
  output logic [cdc_bridge_pkg::DATA_W-1:0] slave_writedata_q
);

  cdc_bridge_pkg::xfer_state_e state_q;
  cdc_bridge_pkg::xfer_state_e state_d;
  logic                        read_req_d;
  logic                        write_req_d;
  logic                        read_done_pulse;
  logic                        write_done_pulse;
  logic                        start;

  // completion tokens coming back from the master domain
  toggle_sync u_read_done_sync (
    .master_clk     (slave_clk),
    .master_reset_n (slave_reset_n),
    .toggle_in      (read_done_toggle),
    .pulse_out      (read_done_pulse)
  );

  toggle_sync u_write_done_sync (
    .master_clk     (slave_clk),
    .master_reset_n (slave_reset_n),
    .toggle_in      (write_done_toggle),
    .pulse_out      (write_done_pulse)
  );

  assign start = (state_q == cdc_bridge_pkg::IDLE) && (slave_read || slave_write);

  // next state, request toggles and waitrequest
  always_comb
  begin
    state_d           = state_q;
    read_req_d        = read_req_toggle;
    write_req_d       = write_req_toggle;
    slave_waitrequest = 1'b0;
    case (state_q)
      cdc_bridge_pkg::IDLE:
      begin
        // read wins if the master ever drives both
        if (slave_read)
        begin
          state_d           = cdc_bridge_pkg::READ_WAIT;
          read_req_d        = ~read_req_toggle;
          slave_waitrequest = 1'b1;
        end
        else if (slave_write)
        begin
          state_d           = cdc_bridge_pkg::WRITE_WAIT;
          write_req_d       = ~write_req_toggle;
          slave_waitrequest = 1'b1;
        end
      end
      cdc_bridge_pkg::READ_WAIT:
      begin
        slave_waitrequest = ~read_done_pulse;
        if (read_done_pulse)
        begin
          state_d = cdc_bridge_pkg::IDLE;
        end
      end
      cdc_bridge_pkg::WRITE_WAIT:
      begin
        slave_waitrequest = ~write_done_pulse;
        if (write_done_pulse)
        begin
          state_d = cdc_bridge_pkg::IDLE;
        end
      end
      default:
      begin
        state_d = cdc_bridge_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge slave_clk or negedge slave_reset_n)
  begin
    if (!slave_reset_n)
    begin
      state_q          <= cdc_bridge_pkg::IDLE;
      read_req_toggle  <= 1'b0;
      write_req_toggle <= 1'b0;
    end
    else
    begin
      state_q          <= state_d;
      read_req_toggle  <= read_req_d;
      write_req_toggle <= write_req_d;
    end
  end

  // address and write data held for the whole transfer
  always_ff @(posedge slave_clk)
  begin
    if (start)
    begin
      slave_address_q   <= slave_address;
      slave_writedata_q <= slave_writedata;
    end
  end

  // read data settles here before the done token gets through
  always_ff @(posedge slave_clk)
  begin
    slave_readdata <= read_capture;
  end

endmodule

/* verilog/toggle_sync.sv */
// toggle synchronizer, turns each level change of a foreign toggle into one local pulse
`timescale 1ns/1ns

module toggle_sync #(
  parameter int depth = cdc_bridge_pkg::SYNC_DEPTH
) (
  input  logic master_clk,
  input  logic master_reset_n,
  input  logic toggle_in,
  output logic pulse_out
);

  // sync_q[0] is the first flop to see the foreign level
  logic [depth-1:0] sync_q;
  logic             delay_q;

  always_ff @(posedge master_clk or negedge master_reset_n)
  begin
    if (!master_reset_n)
    begin
      sync_q  <= '0;
      delay_q <= 1'b0;
    end
    else
    begin
      sync_q[0] <= toggle_in;
      for (int i = 1; i < depth; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
      delay_q <= sync_q[depth-1];
    end
  end

  // high for one cycle after every change of the synchronized level
  assign pulse_out = sync_q[depth-1] ^ delay_q;

endmodule
